// ==== apb_interconnect.sv ====
`timescale 1ns/1ps
`default_nettype none

module apb_interconnect (
  input  wire                 clk_i,
  input  wire                 rst_ni,
  input  wire                 host_psel_i,
  input  wire                 host_penable_i,
  input  wire                 host_pwrite_i,
  input  wire soc_pkg::addr_t host_paddr_i,
  input  wire soc_pkg::data_t host_pwdata_i,
  input  wire soc_pkg::strb_t host_pstrb_i,
  output soc_pkg::data_t      host_prdata_o,
  output logic                host_pready_o,
  output logic                host_pslverr_o,
  input  wire                 dbg_psel_i,
  input  wire                 dbg_penable_i,
  input  wire                 dbg_pwrite_i,
  input  wire soc_pkg::addr_t dbg_paddr_i,
  input  wire soc_pkg::data_t dbg_pwdata_i,
  input  wire soc_pkg::strb_t dbg_pstrb_i,
  output soc_pkg::data_t      dbg_prdata_o,
  output logic                dbg_pready_o,
  output logic                dbg_pslverr_o,
  output logic                rom_psel_o,
  output logic                sram_psel_o,
  output logic                clint_psel_o,
  output logic                penable_o,
  output logic                pwrite_o,
  output soc_pkg::addr_t      paddr_o,
  output soc_pkg::data_t      pwdata_o,
  output soc_pkg::strb_t      pstrb_o,
  input  wire soc_pkg::data_t rom_prdata_i,
  input  wire soc_pkg::data_t sram_prdata_i,
  input  wire soc_pkg::data_t clint_prdata_i,
  input  wire                 rom_pready_i,
  input  wire                 sram_pready_i,
  input  wire                 clint_pready_i,
  input  wire                 rom_pslverr_i,
  input  wire                 sram_pslverr_i,
  input  wire                 clint_pslverr_i
);

  localparam logic [1:0] st_idle   = 2'd0;
  localparam logic [1:0] st_setup  = 2'd1;
  localparam logic [1:0] st_access = 2'd2;

  logic [1:0]         state_q, state_d;
  logic               grant, pick_dbg;
  logic               gnt_dbg_q, tie_dbg_q;
  soc_pkg::bus_addr_u addr_q;
  logic               pwrite_q;
  soc_pkg::data_t     wdata_q;
  soc_pkg::strb_t     strb_q;
  logic               busy, access;
  logic               sel_rom, sel_sram, sel_clint, mapped;
  soc_pkg::data_t     resp_rdata;
  logic               resp_ready, resp_err;
  logic               done;
  logic [2:0]         psel_vec;

  // ----------------------------------------------------------------------
  // Arbitration
  // ----------------------------------------------------------------------
  assign grant = (state_q == st_idle) && (host_psel_i || dbg_psel_i);
  // Tie goes to the port that lost the previous tie
  assign pick_dbg = dbg_psel_i && (!host_psel_i || !tie_dbg_q);

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle:   if (grant) state_d = st_setup;
      st_setup:  state_d = st_access;
      st_access: if (done) state_d = st_idle;
      default:   state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= st_idle;
      gnt_dbg_q <= 1'b0;
      tie_dbg_q <= 1'b1;
    end else begin
      state_q <= state_d;
      if (grant) gnt_dbg_q <= pick_dbg;
      if (grant && host_psel_i && dbg_psel_i) tie_dbg_q <= pick_dbg;
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant) begin
      addr_q.raw <= pick_dbg ? dbg_paddr_i   : host_paddr_i;
      pwrite_q   <= pick_dbg ? dbg_pwrite_i  : host_pwrite_i;
      wdata_q    <= pick_dbg ? dbg_pwdata_i  : host_pwdata_i;
      strb_q     <= pick_dbg ? dbg_pstrb_i   : host_pstrb_i;
    end
  end

  // ----------------------------------------------------------------------
  // Region decode and downstream phases
  // ----------------------------------------------------------------------
  assign sel_rom   = addr_q.f.region == soc_pkg::region_rom;
  assign sel_sram  = addr_q.f.region == soc_pkg::region_sram;
  assign sel_clint = addr_q.f.region == soc_pkg::region_clint;
  assign mapped    = sel_rom || sel_sram || sel_clint;

  assign busy   = state_q != st_idle;
  assign access = state_q == st_access;

  assign rom_psel_o   = busy && sel_rom;
  assign sram_psel_o  = busy && sel_sram;
  assign clint_psel_o = busy && sel_clint;
  assign penable_o    = access && mapped;
  assign pwrite_o     = pwrite_q;
  assign paddr_o      = addr_q.raw;
  assign pwdata_o     = wdata_q;
  assign pstrb_o      = strb_q;

  // Unmapped regions answer here with an error
  always_comb begin
    resp_rdata = '0;
    resp_ready = 1'b1;
    resp_err   = 1'b1;
    if (sel_rom) begin
      resp_rdata = rom_prdata_i;
      resp_ready = rom_pready_i;
      resp_err   = rom_pslverr_i;
    end else if (sel_sram) begin
      resp_rdata = sram_prdata_i;
      resp_ready = sram_pready_i;
      resp_err   = sram_pslverr_i;
    end else if (sel_clint) begin
      resp_rdata = clint_prdata_i;
      resp_ready = clint_pready_i;
      resp_err   = clint_pslverr_i;
    end
  end

  assign done = access && resp_ready && (gnt_dbg_q ? dbg_penable_i : host_penable_i);

  assign host_pready_o  = done && !gnt_dbg_q;
  assign host_pslverr_o = done && !gnt_dbg_q && resp_err;
  assign host_prdata_o  = (done && !gnt_dbg_q) ? resp_rdata : '0;
  assign dbg_pready_o   = done && gnt_dbg_q;
  assign dbg_pslverr_o  = done && gnt_dbg_q && resp_err;
  assign dbg_prdata_o   = (done && gnt_dbg_q) ? resp_rdata : '0;

  assign psel_vec = {rom_psel_o, sram_psel_o, clint_psel_o};

  a_one_select: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(psel_vec));

  // Access phase always comes out of a setup phase on the same peer
  a_setup_first: assert property (@(posedge clk_i) disable iff (!rst_ni)
    penable_o |-> $past(psel_vec != 3'b000 && !penable_o) && $stable(psel_vec));

endmodule

`default_nettype wire

// ==== boot_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

module boot_rom (
  input  wire                 clk_i,
  input  wire                 rst_ni,
  input  wire                 psel_i,
  input  wire                 penable_i,
  input  wire                 pwrite_i,
  input  wire soc_pkg::addr_t paddr_i,
  output soc_pkg::data_t      prdata_o,
  output logic                pready_o,
  output logic                pslverr_o
);

  localparam int unsigned idx_width = $clog2(soc_pkg::rom_words);

  soc_pkg::bus_addr_u addr;
  logic [21:0]        word_idx;

  assign addr.raw = paddr_i;
  assign word_idx = addr.f.offset[23:2];

  // Reads past the image return zero
  assign prdata_o = (word_idx < soc_pkg::rom_words) ?
                    soc_pkg::boot_image[word_idx[idx_width-1:0]] : '0;

  assign pready_o  = 1'b1;
  assign pslverr_o = psel_i && penable_i && pwrite_i;

  a_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (psel_i && !penable_i) ##1 penable_i |-> $stable(paddr_i));

endmodule

`default_nettype wire

// ==== clint.sv ====
`timescale 1ns/1ps
`default_nettype none

module clint (
  input  wire                 clk_i,
  input  wire                 rst_ni,
  input  wire                 rtc_i,
  input  wire                 psel_i,
  input  wire                 penable_i,
  input  wire                 pwrite_i,
  input  wire soc_pkg::addr_t paddr_i,
  input  wire soc_pkg::data_t pwdata_i,
  input  wire soc_pkg::strb_t pstrb_i,
  output soc_pkg::data_t      prdata_o,
  output logic                pready_o,
  output logic                pslverr_o,
  output logic                timer_irq_o,
  output logic                ipi_o
);

  logic [1:0]         rtc_sync_q;
  logic               rtc_prev_q;
  logic               rtc_rise;
  logic [63:0]        mtime_q;
  logic [63:0]        mtimecmp_q;
  logic               msip_q;
  logic               timer_irq_q;
  soc_pkg::bus_addr_u addr;
  logic               wr_en;
  logic               reg_hit;

  function automatic soc_pkg::data_t merge(input soc_pkg::data_t old_d,
                                           input soc_pkg::data_t new_d,
                                           input soc_pkg::strb_t strb);
    soc_pkg::data_t res;
    res = old_d;
    for (int i = 0; i < soc_pkg::strb_width; i++) begin
      if (strb[i]) res[8*i +: 8] = new_d[8*i +: 8];
    end
    return res;
  endfunction

  assign addr.raw = paddr_i;
  assign wr_en    = psel_i && penable_i && pwrite_i;

  // ----------------------------------------------------------------------
  // RTC synchronizer and edge detect
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rtc_sync_q <= 2'b00;
      rtc_prev_q <= 1'b0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[0], rtc_i};
      rtc_prev_q <= rtc_sync_q[1];
    end
  end

  assign rtc_rise = rtc_sync_q[1] && !rtc_prev_q;

  // ----------------------------------------------------------------------
  // Registers
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mtime_q     <= '0;
      mtimecmp_q  <= '1;
      msip_q      <= 1'b0;
      timer_irq_q <= 1'b0;
    end else begin
      timer_irq_q <= mtime_q >= mtimecmp_q;
      // Bus write wins over a tick in the same cycle
      if (wr_en && addr.f.offset == soc_pkg::clint_mtime_lo_off) begin
        mtime_q[31:0] <= merge(mtime_q[31:0], pwdata_i, pstrb_i);
      end else if (wr_en && addr.f.offset == soc_pkg::clint_mtime_hi_off) begin
        mtime_q[63:32] <= merge(mtime_q[63:32], pwdata_i, pstrb_i);
      end else if (rtc_rise) begin
        mtime_q <= mtime_q + 64'd1;
      end
      if (wr_en && addr.f.offset == soc_pkg::clint_mtimecmp_lo_off) begin
        mtimecmp_q[31:0] <= merge(mtimecmp_q[31:0], pwdata_i, pstrb_i);
      end
      if (wr_en && addr.f.offset == soc_pkg::clint_mtimecmp_hi_off) begin
        mtimecmp_q[63:32] <= merge(mtimecmp_q[63:32], pwdata_i, pstrb_i);
      end
      if (wr_en && addr.f.offset == soc_pkg::clint_msip_off && pstrb_i[0]) begin
        msip_q <= pwdata_i[0];
      end
    end
  end

  always_comb begin
    prdata_o = '0;
    reg_hit  = 1'b1;
    case (addr.f.offset)
      soc_pkg::clint_msip_off:        prdata_o = soc_pkg::data_t'(msip_q);
      soc_pkg::clint_mtimecmp_lo_off: prdata_o = mtimecmp_q[31:0];
      soc_pkg::clint_mtimecmp_hi_off: prdata_o = mtimecmp_q[63:32];
      soc_pkg::clint_mtime_lo_off:    prdata_o = mtime_q[31:0];
      soc_pkg::clint_mtime_hi_off:    prdata_o = mtime_q[63:32];
      default:                        reg_hit  = 1'b0;
    endcase
  end

  assign pready_o    = 1'b1;
  assign pslverr_o   = psel_i && penable_i && !reg_hit;
  assign timer_irq_o = timer_irq_q;
  assign ipi_o       = msip_q;

endmodule

`default_nettype wire

// ==== soc_pkg.sv ====
`default_nettype none

package soc_pkg;

  localparam int unsigned addr_width = 32;
  localparam int unsigned data_width = 32;
  localparam int unsigned strb_width = data_width / 8;

  typedef logic [addr_width-1:0] addr_t;
  typedef logic [data_width-1:0] data_t;
  typedef logic [strb_width-1:0] strb_t;
  typedef logic [7:0]            region_t;

  // Memory map, selected by the top address byte
  localparam region_t region_rom   = 8'h00;
  localparam region_t region_clint = 8'h02;
  localparam region_t region_sram  = 8'h80;

  // One address word, seen as raw bits or as region plus offset
  typedef union packed {
    addr_t raw;
    struct packed {
      region_t     region;
      logic [23:0] offset;
    } f;
  } bus_addr_u;

  localparam int unsigned rom_words = 16;

  localparam data_t boot_image [rom_words] = '{
    32'h0000_0297, 32'h0202_8593, 32'hf140_2573, 32'h0182_b283,
    32'h0002_8067, 32'h0000_0013, 32'h0000_0013, 32'h0000_0013,
    32'h8000_0000, 32'h0000_0000, 32'h1050_0073, 32'hffdf_f06f,
    32'hdead_beef, 32'hcafe_f00d, 32'h0123_4567, 32'h89ab_cdef
  };

  // CLINT register offsets within its region
  localparam logic [23:0] clint_msip_off        = 24'h00_0000;
  localparam logic [23:0] clint_mtimecmp_lo_off = 24'h00_4000;
  localparam logic [23:0] clint_mtimecmp_hi_off = 24'h00_4004;
  localparam logic [23:0] clint_mtime_lo_off    = 24'h00_bff8;
  localparam logic [23:0] clint_mtime_hi_off    = 24'h00_bffc;

endpackage

`default_nettype wire

// ==== soc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_top #(
  parameter int unsigned sram_words = 1024
) (
  input  wire                 clk_i,
  input  wire                 rst_ni,
  input  wire                 rtc_i,
  input  wire                 host_psel_i,
  input  wire                 host_penable_i,
  input  wire                 host_pwrite_i,
  input  wire soc_pkg::addr_t host_paddr_i,
  input  wire soc_pkg::data_t host_pwdata_i,
  input  wire soc_pkg::strb_t host_pstrb_i,
  output soc_pkg::data_t      host_prdata_o,
  output logic                host_pready_o,
  output logic                host_pslverr_o,
  input  wire                 dbg_psel_i,
  input  wire                 dbg_penable_i,
  input  wire                 dbg_pwrite_i,
  input  wire soc_pkg::addr_t dbg_paddr_i,
  input  wire soc_pkg::data_t dbg_pwdata_i,
  input  wire soc_pkg::strb_t dbg_pstrb_i,
  output soc_pkg::data_t      dbg_prdata_o,
  output logic                dbg_pready_o,
  output logic                dbg_pslverr_o,
  output logic                timer_irq_o,
  output logic                ipi_o
);

  // Shared downstream bus
  logic           rom_psel, sram_psel, clint_psel;
  logic           penable, pwrite;
  soc_pkg::addr_t paddr;
  soc_pkg::data_t pwdata;
  soc_pkg::strb_t pstrb;
  soc_pkg::data_t rom_prdata, sram_prdata, clint_prdata;
  logic           rom_pready, sram_pready, clint_pready;
  logic           rom_pslverr, sram_pslverr, clint_pslverr;

  apb_interconnect apb_interconnect_inst (
    .clk_i           ( clk_i          ),
    .rst_ni          ( rst_ni         ),
    .host_psel_i     ( host_psel_i    ),
    .host_penable_i  ( host_penable_i ),
    .host_pwrite_i   ( host_pwrite_i  ),
    .host_paddr_i    ( host_paddr_i   ),
    .host_pwdata_i   ( host_pwdata_i  ),
    .host_pstrb_i    ( host_pstrb_i   ),
    .host_prdata_o   ( host_prdata_o  ),
    .host_pready_o   ( host_pready_o  ),
    .host_pslverr_o  ( host_pslverr_o ),
    .dbg_psel_i      ( dbg_psel_i     ),
    .dbg_penable_i   ( dbg_penable_i  ),
    .dbg_pwrite_i    ( dbg_pwrite_i   ),
    .dbg_paddr_i     ( dbg_paddr_i    ),
    .dbg_pwdata_i    ( dbg_pwdata_i   ),
    .dbg_pstrb_i     ( dbg_pstrb_i    ),
    .dbg_prdata_o    ( dbg_prdata_o   ),
    .dbg_pready_o    ( dbg_pready_o   ),
    .dbg_pslverr_o   ( dbg_pslverr_o  ),
    .rom_psel_o      ( rom_psel       ),
    .sram_psel_o     ( sram_psel      ),
    .clint_psel_o    ( clint_psel     ),
    .penable_o       ( penable        ),
    .pwrite_o        ( pwrite         ),
    .paddr_o         ( paddr          ),
    .pwdata_o        ( pwdata         ),
    .pstrb_o         ( pstrb          ),
    .rom_prdata_i    ( rom_prdata     ),
    .sram_prdata_i   ( sram_prdata    ),
    .clint_prdata_i  ( clint_prdata   ),
    .rom_pready_i    ( rom_pready     ),
    .sram_pready_i   ( sram_pready    ),
    .clint_pready_i  ( clint_pready   ),
    .rom_pslverr_i   ( rom_pslverr    ),
    .sram_pslverr_i  ( sram_pslverr   ),
    .clint_pslverr_i ( clint_pslverr  )
  );

  boot_rom boot_rom_inst (
    .clk_i     ( clk_i       ),
    .rst_ni    ( rst_ni      ),
    .psel_i    ( rom_psel    ),
    .penable_i ( penable     ),
    .pwrite_i  ( pwrite      ),
    .paddr_i   ( paddr       ),
    .prdata_o  ( rom_prdata  ),
    .pready_o  ( rom_pready  ),
    .pslverr_o ( rom_pslverr )
  );

  sram #(
    .sram_words ( sram_words )
  ) sram_inst (
    .clk_i     ( clk_i        ),
    .rst_ni    ( rst_ni       ),
    .psel_i    ( sram_psel    ),
    .penable_i ( penable      ),
    .pwrite_i  ( pwrite       ),
    .paddr_i   ( paddr        ),
    .pwdata_i  ( pwdata       ),
    .pstrb_i   ( pstrb        ),
    .prdata_o  ( sram_prdata  ),
    .pready_o  ( sram_pready  ),
    .pslverr_o ( sram_pslverr )
  );

  clint clint_inst (
    .clk_i       ( clk_i         ),
    .rst_ni      ( rst_ni        ),
    .rtc_i       ( rtc_i         ),
    .psel_i      ( clint_psel    ),
    .penable_i   ( penable       ),
    .pwrite_i    ( pwrite        ),
    .paddr_i     ( paddr         ),
    .pwdata_i    ( pwdata        ),
    .pstrb_i     ( pstrb         ),
    .prdata_o    ( clint_prdata  ),
    .pready_o    ( clint_pready  ),
    .pslverr_o   ( clint_pslverr ),
    .timer_irq_o ( timer_irq_o   ),
    .ipi_o       ( ipi_o         )
  );

endmodule

`default_nettype wire

// ==== sram.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram #(
  parameter int unsigned sram_words = 1024
) (
  input  wire                 clk_i,
  input  wire                 rst_ni,
  input  wire                 psel_i,
  input  wire                 penable_i,
  input  wire                 pwrite_i,
  input  wire soc_pkg::addr_t paddr_i,
  input  wire soc_pkg::data_t pwdata_i,
  input  wire soc_pkg::strb_t pstrb_i,
  output soc_pkg::data_t      prdata_o,
  output logic                pready_o,
  output logic                pslverr_o
);

  localparam int unsigned idx_width = $clog2(sram_words);

  soc_pkg::data_t       mem [sram_words];
  soc_pkg::bus_addr_u   addr;
  logic [idx_width-1:0] idx;

  assign addr.raw = paddr_i;
  // Word index wraps at the array depth
  assign idx = addr.f.offset[idx_width+1:2];

  always_ff @(posedge clk_i) begin
    if (psel_i && penable_i && pwrite_i) begin
      for (int i = 0; i < soc_pkg::strb_width; i++) begin
        if (pstrb_i[i]) mem[idx][8*i +: 8] <= pwdata_i[8*i +: 8];
      end
    end
  end

  assign prdata_o  = mem[idx];
  assign pready_o  = 1'b1;
  assign pslverr_o = 1'b0;

  a_write_strobe: assert property (@(posedge clk_i) disable iff (!rst_ni)
    psel_i && penable_i && pwrite_i |-> pstrb_i != '0);

endmodule

`default_nettype wire

// ==== tb.f ====
soc_pkg.sv
apb_interconnect.sv
boot_rom.sv
sram.sv
clint.sv
soc_top.sv
tb_soc.sv

// ==== tb_soc.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_soc;

  localparam int timeout_cycles = 50;
  localparam soc_pkg::addr_t sram_base = 32'h8000_0000;
  localparam soc_pkg::addr_t clint_msip = {soc_pkg::region_clint, soc_pkg::clint_msip_off};
  localparam soc_pkg::addr_t clint_cmp_lo = {soc_pkg::region_clint,
                                             soc_pkg::clint_mtimecmp_lo_off};
  localparam soc_pkg::addr_t clint_cmp_hi = {soc_pkg::region_clint,
                                             soc_pkg::clint_mtimecmp_hi_off};
  localparam soc_pkg::addr_t clint_time_lo = {soc_pkg::region_clint,
                                              soc_pkg::clint_mtime_lo_off};
  localparam soc_pkg::addr_t clint_time_hi = {soc_pkg::region_clint,
                                              soc_pkg::clint_mtime_hi_off};

  logic           clk_i, rst_ni, rtc_i;
  logic           host_psel_i, host_penable_i, host_pwrite_i;
  soc_pkg::addr_t host_paddr_i;
  soc_pkg::data_t host_pwdata_i;
  soc_pkg::strb_t host_pstrb_i;
  soc_pkg::data_t host_prdata_o;
  logic           host_pready_o, host_pslverr_o;
  logic           dbg_psel_i, dbg_penable_i, dbg_pwrite_i;
  soc_pkg::addr_t dbg_paddr_i;
  soc_pkg::data_t dbg_pwdata_i;
  soc_pkg::strb_t dbg_pstrb_i;
  soc_pkg::data_t dbg_prdata_o;
  logic           dbg_pready_o, dbg_pslverr_o;
  logic           timer_irq_o, ipi_o;

  int  seed = 32'h7049_9feb;
  time host_done_t, dbg_done_t;

  soc_top #(
    .sram_words ( 1024 )
  ) soc_top_inst (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .rtc_i          ( rtc_i          ),
    .host_psel_i    ( host_psel_i    ),
    .host_penable_i ( host_penable_i ),
    .host_pwrite_i  ( host_pwrite_i  ),
    .host_paddr_i   ( host_paddr_i   ),
    .host_pwdata_i  ( host_pwdata_i  ),
    .host_pstrb_i   ( host_pstrb_i   ),
    .host_prdata_o  ( host_prdata_o  ),
    .host_pready_o  ( host_pready_o  ),
    .host_pslverr_o ( host_pslverr_o ),
    .dbg_psel_i     ( dbg_psel_i     ),
    .dbg_penable_i  ( dbg_penable_i  ),
    .dbg_pwrite_i   ( dbg_pwrite_i   ),
    .dbg_paddr_i    ( dbg_paddr_i    ),
    .dbg_pwdata_i   ( dbg_pwdata_i   ),
    .dbg_pstrb_i    ( dbg_pstrb_i    ),
    .dbg_prdata_o   ( dbg_prdata_o   ),
    .dbg_pready_o   ( dbg_pready_o   ),
    .dbg_pslverr_o  ( dbg_pslverr_o  ),
    .timer_irq_o    ( timer_irq_o    ),
    .ipi_o          ( ipi_o          )
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // ----------------------------------------------------------------------
  // Failure reporting and checks
  // ----------------------------------------------------------------------
  task automatic abort_run(input string why);
    $display("sim failed");
    $fatal(1, "%s", why);
  endtask

  task automatic check_data(input soc_pkg::data_t got, input soc_pkg::data_t exp,
                            input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s read %h, expected %h", $time, what, got, exp);
      abort_run("wrong data value");
    end
  endtask

  task automatic check_err(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s pslverr %b, expected %b", $time, what, got, exp);
      abort_run("wrong error response");
    end
  endtask

  task automatic check_irq(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
      abort_run("wrong interrupt level");
    end
  endtask

  task automatic check_order(input time early, input time late, input string what);
    if (!(early < late)) begin
      $display("MISMATCH at %0t: %s, done at %0t and %0t", $time, what, early, late);
      abort_run("wrong completion order");
    end
  endtask

  // Expected word after a strobed write
  function automatic soc_pkg::data_t byte_merge(input soc_pkg::data_t old_w,
                                                input soc_pkg::data_t new_w,
                                                input soc_pkg::strb_t strb);
    soc_pkg::data_t mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  // ----------------------------------------------------------------------
  // APB requester tasks
  // ----------------------------------------------------------------------
  task automatic host_xfer(input logic wr, input soc_pkg::addr_t addr,
                           input soc_pkg::data_t wdata, input soc_pkg::strb_t strb,
                           output soc_pkg::data_t rdata, output logic err);
    int cycles = 0;
    @(posedge clk_i);
    host_psel_i   <= 1'b1;
    host_pwrite_i <= wr;
    host_paddr_i  <= addr;
    host_pwdata_i <= wdata;
    host_pstrb_i  <= strb;
    @(posedge clk_i);
    host_penable_i <= 1'b1;
    @(negedge clk_i);
    while (!host_pready_o && cycles < timeout_cycles) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!host_pready_o) abort_run("host port saw no pready before the timeout");
    rdata       = host_prdata_o;
    err         = host_pslverr_o;
    host_done_t = $time;
    @(posedge clk_i);
    host_psel_i    <= 1'b0;
    host_penable_i <= 1'b0;
  endtask

  task automatic dbg_xfer(input logic wr, input soc_pkg::addr_t addr,
                          input soc_pkg::data_t wdata, input soc_pkg::strb_t strb,
                          output soc_pkg::data_t rdata, output logic err);
    int cycles = 0;
    @(posedge clk_i);
    dbg_psel_i   <= 1'b1;
    dbg_pwrite_i <= wr;
    dbg_paddr_i  <= addr;
    dbg_pwdata_i <= wdata;
    dbg_pstrb_i  <= strb;
    @(posedge clk_i);
    dbg_penable_i <= 1'b1;
    @(negedge clk_i);
    while (!dbg_pready_o && cycles < timeout_cycles) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!dbg_pready_o) abort_run("debug port saw no pready before the timeout");
    rdata      = dbg_prdata_o;
    err        = dbg_pslverr_o;
    dbg_done_t = $time;
    @(posedge clk_i);
    dbg_psel_i    <= 1'b0;
    dbg_penable_i <= 1'b0;
  endtask

  task automatic host_write(input soc_pkg::addr_t addr, input soc_pkg::data_t wdata,
                            input soc_pkg::strb_t strb, output logic err);
    soc_pkg::data_t ignored;
    host_xfer(1'b1, addr, wdata, strb, ignored, err);
  endtask

  task automatic host_read(input soc_pkg::addr_t addr, output soc_pkg::data_t rdata,
                           output logic err);
    host_xfer(1'b0, addr, '0, '0, rdata, err);
  endtask

  task automatic dbg_write(input soc_pkg::addr_t addr, input soc_pkg::data_t wdata,
                           input soc_pkg::strb_t strb, output logic err);
    soc_pkg::data_t ignored;
    dbg_xfer(1'b1, addr, wdata, strb, ignored, err);
  endtask

  task automatic dbg_read(input soc_pkg::addr_t addr, output soc_pkg::data_t rdata,
                          output logic err);
    dbg_xfer(1'b0, addr, '0, '0, rdata, err);
  endtask

  // One full rtc period, long enough to pass the synchronizer
  task automatic rtc_pulse();
    @(posedge clk_i);
    rtc_i <= 1'b1;
    repeat (4) @(posedge clk_i);
    rtc_i <= 1'b0;
    repeat (4) @(posedge clk_i);
  endtask

  task automatic wait_timer_irq();
    int cycles = 0;
    @(negedge clk_i);
    while (!timer_irq_o && cycles < timeout_cycles) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!timer_irq_o) abort_run("timer interrupt did not rise before the timeout");
  endtask

  // ----------------------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------------------
  task automatic reset_outputs_low();
    @(negedge clk_i);
    check_irq(host_pready_o, 1'b0, "host_pready_o after reset");
    check_irq(dbg_pready_o, 1'b0, "dbg_pready_o after reset");
    check_irq(timer_irq_o, 1'b0, "timer_irq_o after reset");
    check_irq(ipi_o, 1'b0, "ipi_o after reset");
  endtask

  task automatic sram_shared_strobes();
    soc_pkg::data_t exp_w [4];
    soc_pkg::data_t rd, patch;
    logic           err;
    for (int i = 0; i < 4; i++) begin
      exp_w[i] = $random(seed);
      host_write(sram_base + 4 * i, exp_w[i], 4'hf, err);
      check_err(err, 1'b0, "sram write");
    end
    patch = $random(seed);
    host_write(sram_base + 4, patch, 4'b0101, err);
    check_err(err, 1'b0, "sram partial write");
    exp_w[1] = byte_merge(exp_w[1], patch, 4'b0101);
    for (int i = 0; i < 4; i++) begin
      dbg_read(sram_base + 4 * i, rd, err);
      check_data(rd, exp_w[i], $sformatf("sram word %0d", i));
      check_err(err, 1'b0, "sram read");
    end
  endtask

  task automatic boot_rom_image();
    soc_pkg::data_t rd;
    logic           err;
    for (int i = 0; i < soc_pkg::rom_words; i++) begin
      host_read(4 * i, rd, err);
      check_data(rd, soc_pkg::boot_image[i], $sformatf("rom word %0d", i));
      check_err(err, 1'b0, "rom read");
    end
    host_read(4 * soc_pkg::rom_words, rd, err);
    check_data(rd, '0, "rom past image");
    host_write(32'h8, 32'h1234_5678, 4'hf, err);
    check_err(err, 1'b1, "rom write");
    host_read(32'h8, rd, err);
    check_data(rd, soc_pkg::boot_image[2], "rom word after write");
  endtask

  task automatic unmapped_region_error();
    soc_pkg::data_t rd;
    logic           err;
    host_read(32'h4000_0010, rd, err);
    check_data(rd, '0, "unmapped read");
    check_err(err, 1'b1, "unmapped read");
  endtask

  task automatic contention_order();
    soc_pkg::data_t exp_w [4];
    soc_pkg::data_t rd;
    logic           host_err, dbg_err, err;
    for (int i = 0; i < 4; i++) exp_w[i] = $random(seed);
    fork
      host_write(sram_base + 'h40, exp_w[0], 4'hf, host_err);
      dbg_write(sram_base + 'h44, exp_w[1], 4'hf, dbg_err);
    join
    check_err(host_err, 1'b0, "first contended host write");
    check_err(dbg_err, 1'b0, "first contended debug write");
    check_order(host_done_t, dbg_done_t, "first tie goes to host");
    fork
      host_write(sram_base + 'h48, exp_w[2], 4'hf, host_err);
      dbg_write(sram_base + 'h4c, exp_w[3], 4'hf, dbg_err);
    join
    check_err(host_err, 1'b0, "second contended host write");
    check_err(dbg_err, 1'b0, "second contended debug write");
    check_order(dbg_done_t, host_done_t, "second tie goes to debug");
    for (int i = 0; i < 4; i++) begin
      host_read(sram_base + 'h40 + 4 * i, rd, err);
      check_data(rd, exp_w[i], $sformatf("contended word %0d", i));
      check_err(err, 1'b0, "contended read");
    end
  endtask

  task automatic clint_interrupts();
    soc_pkg::data_t rd;
    logic           err;
    host_write(clint_msip, 32'h1, 4'hf, err);
    check_err(err, 1'b0, "msip set write");
    @(negedge clk_i);
    check_irq(ipi_o, 1'b1, "ipi_o after msip set");
    dbg_write(clint_msip, 32'h0, 4'hf, err);
    check_err(err, 1'b0, "msip clear write");
    @(negedge clk_i);
    check_irq(ipi_o, 1'b0, "ipi_o after msip clear");
    host_write(clint_time_lo, 32'h0, 4'hf, err);
    host_write(clint_time_hi, 32'h0, 4'hf, err);
    host_write(clint_cmp_lo, 32'h3, 4'hf, err);
    host_write(clint_cmp_hi, 32'h0, 4'hf, err);
    check_err(err, 1'b0, "mtimecmp write");
    @(negedge clk_i);
    check_irq(timer_irq_o, 1'b0, "timer_irq_o before rtc");
    for (int i = 0; i < 2; i++) begin
      rtc_pulse();
      @(negedge clk_i);
      check_irq(timer_irq_o, 1'b0, $sformatf("timer_irq_o after rtc edge %0d", i + 1));
    end
    @(posedge clk_i);
    rtc_i <= 1'b1;
    wait_timer_irq();
    @(posedge clk_i);
    rtc_i <= 1'b0;
    host_read(clint_time_lo, rd, err);
    check_data(rd, 32'h3, "mtime after three rtc edges");
    check_err(err, 1'b0, "mtime read");
  endtask

  initial begin
    rst_ni         = 1'b0;
    rtc_i          = 1'b0;
    host_psel_i    = 1'b0;
    host_penable_i = 1'b0;
    host_pwrite_i  = 1'b0;
    host_paddr_i   = '0;
    host_pwdata_i  = '0;
    host_pstrb_i   = '0;
    dbg_psel_i     = 1'b0;
    dbg_penable_i  = 1'b0;
    dbg_pwrite_i   = 1'b0;
    dbg_paddr_i    = '0;
    dbg_pwdata_i   = '0;
    dbg_pstrb_i    = '0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;

    reset_outputs_low();
    sram_shared_strobes();
    boot_rom_image();
    unmapped_region_error();
    contention_order();
    clint_interrupts();

    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire
